// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module savestate_tb -f savestate_top.f -o savestate_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/savestate_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// ==== savestate_top.f ====
src/savestate_pkg.sv
src/cpu_state_pkg.sv
src/ss_bus_if.sv
src/ss_request_stage.sv
src/core_registers.sv
src/clock_timer.sv
src/state_ram.sv
src/ss_readback_stage.sv
src/savestate_top.sv
test/savestate_checker.sv
test/savestate_monitor.sv
test/savestate_tb.sv

// ==== src/clock_timer.sv ====
`timescale 1ns/1ps

module clock_timer (
    input  logic     clk,
    input  logic     reset,
    input  logic     run,
    ss_bus_if.target bus
);

    logic [6:0] divider;
    logic [7:0] counter_256;
    // Pulses for one count after each divider wrap
    logic       tick;

    always_ff @(posedge clk) begin
        if (reset) begin
            divider     <= '0;
            counter_256 <= '0;
            tick        <= 1'b0;
        end else if (bus.write) begin
            // Host load wins over counting
            if (bus.offset == 8'd0) begin
                {tick, divider, counter_256} <= bus.wdata[15:0];
            end
        end else if (run) begin
            divider <= divider + 7'd1;
            if (divider == 7'h7f) begin
                counter_256 <= counter_256 + 8'd1;
                tick        <= 1'b1;
            end else begin
                tick <= 1'b0;
            end
        end
    end

    always_comb begin
        if (bus.offset == 8'd0) begin
            bus.rdata = {16'b0, tick, divider, counter_256};
        end else begin
            bus.rdata = '0;
        end
    end

endmodule

// ==== src/core_registers.sv ====
`timescale 1ns/1ps

module core_registers (
    input  logic     clk,
    input  logic     reset,
    ss_bus_if.target bus
);
    import cpu_state_pkg::*;

    pc_t     pc;
    np_t     np;
    nibble_t a;
    nibble_t b;
    index_t  x;
    index_t  y;
    sp_t     sp;

    // Flags
    logic interrupt;
    logic decimal;
    logic zero;
    logic carry;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= PC_RESET;
            np        <= NP_RESET;
            a         <= '0;
            b         <= '0;
            x         <= '0;
            y         <= '0;
            sp        <= '0;
            interrupt <= 1'b0;
            decimal   <= 1'b0;
            zero      <= 1'b0;
            carry     <= 1'b0;
        end else if (bus.write) begin
            case (bus.offset)
                // Top two bits are reserved
                8'd0: {np, pc, a, b, interrupt, decimal, zero, carry} <= bus.wdata[29:0];
                8'd1: {x, y, sp} <= bus.wdata;
                default: ;
            endcase
        end
    end

    // Same layout as the write side
    always_comb begin
        case (bus.offset)
            8'd0:    bus.rdata = {2'b0, np, pc, a, b, interrupt, decimal, zero, carry};
            8'd1:    bus.rdata = {x, y, sp};
            default: bus.rdata = '0;
        endcase
    end

endmodule

// ==== src/cpu_state_pkg.sv ====
package cpu_state_pkg;

    // Native data width of the core
    typedef logic [3:0] nibble_t;

    // Program counter including bank and page
    typedef logic [12:0] pc_t;

    // Page loaded into pc on the next jump
    typedef logic [4:0] np_t;

    // Index registers x and y
    typedef logic [11:0] index_t;

    // Stack pointer
    typedef logic [7:0] sp_t;

    // Execution starts at page 1, step 0
    localparam pc_t PC_RESET = 13'h0100;
    localparam np_t NP_RESET = 5'h01;

endpackage

// ==== src/savestate_pkg.sv ====
package savestate_pkg;

    // Host bus widths
    typedef logic [7:0]  ss_addr_t;
    typedef logic [31:0] ss_word_t;

    // Word index relative to the start of a region
    typedef logic [7:0]  ss_offset_t;

    // Which block a registered request is aimed at
    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_REGS,
        REGION_TIMER,
        REGION_RAM
    } ss_region_t;

    // Core registers take two words
    localparam ss_addr_t SS_ADDR_REGS0 = 8'h00;
    localparam ss_addr_t SS_ADDR_REGS1 = 8'h01;

    // Clock timer takes a single word
    localparam ss_addr_t SS_ADDR_TIMER = 8'h02;

    // RAM starts here with eight nibbles per word
    localparam ss_addr_t SS_ADDR_RAM_BASE = 8'h10;

endpackage

// ==== src/savestate_top.sv ====
`timescale 1ns/1ps

module savestate_top #(
    parameter int RAM_WORDS = 80
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,
    input  savestate_pkg::ss_addr_t ss_bus_addr,
    input  savestate_pkg::ss_word_t ss_bus_in,
    input  logic                    ss_bus_wren,
    output savestate_pkg::ss_word_t ss_bus_out
);
    import savestate_pkg::*;

    // Region of the request held in the first stage
    ss_region_t region;

    ss_bus_if regs_bus ();
    ss_bus_if timer_bus ();
    ss_bus_if ram_bus ();

    ss_request_stage #(
        .RAM_WORDS(RAM_WORDS)
    ) request (
        .clk        (clk),
        .reset      (reset),
        .ss_bus_addr(ss_bus_addr),
        .ss_bus_in  (ss_bus_in),
        .ss_bus_wren(ss_bus_wren),
        .region     (region),
        .regs_bus   (regs_bus.requester),
        .timer_bus  (timer_bus.requester),
        .ram_bus    (ram_bus.requester)
    );

    core_registers regs (
        .clk  (clk),
        .reset(reset),
        .bus  (regs_bus.target)
    );

    clock_timer clock (
        .clk  (clk),
        .reset(reset),
        .run  (run),
        .bus  (timer_bus.target)
    );

    state_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) ram (
        .clk(clk),
        .bus(ram_bus.target)
    );

    ss_readback_stage readback (
        .clk       (clk),
        .reset     (reset),
        .region    (region),
        .regs_bus  (regs_bus.reader),
        .timer_bus (timer_bus.reader),
        .ram_bus   (ram_bus.reader),
        .ss_bus_out(ss_bus_out)
    );

endmodule

// ==== src/ss_bus_if.sv ====
`timescale 1ns/1ps

interface ss_bus_if;
    import savestate_pkg::*;

    // Word offset inside the target region
    ss_offset_t offset;
    ss_word_t   wdata;
    // High only for requests decoded into this target
    logic       write;
    // Combinational read word at offset
    ss_word_t   rdata;

    modport requester (
        output offset,
        output wdata,
        output write
    );

    modport target (
        input  offset,
        input  wdata,
        input  write,
        output rdata
    );

    modport reader (
        input  rdata
    );

endinterface

// ==== src/ss_readback_stage.sv ====
`timescale 1ns/1ps

module ss_readback_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  savestate_pkg::ss_region_t region,
    ss_bus_if.reader                  regs_bus,
    ss_bus_if.reader                  timer_bus,
    ss_bus_if.reader                  ram_bus,
    output savestate_pkg::ss_word_t   ss_bus_out
);
    import savestate_pkg::*;

    ss_word_t read_word;

    // Unmapped addresses read back as zero
    always_comb begin
        case (region)
            REGION_REGS:  read_word = regs_bus.rdata;
            REGION_TIMER: read_word = timer_bus.rdata;
            REGION_RAM:   read_word = ram_bus.rdata;
            default:      read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ss_bus_out <= '0;
        end else begin
            ss_bus_out <= read_word;
        end
    end

endmodule

// ==== src/ss_request_stage.sv ====
`timescale 1ns/1ps

module ss_request_stage #(
    parameter int RAM_WORDS = 80
) (
    input  logic                    clk,
    input  logic                    reset,
    input  savestate_pkg::ss_addr_t ss_bus_addr,
    input  savestate_pkg::ss_word_t ss_bus_in,
    input  logic                    ss_bus_wren,
    output savestate_pkg::ss_region_t region,
    ss_bus_if.requester             regs_bus,
    ss_bus_if.requester             timer_bus,
    ss_bus_if.requester             ram_bus
);
    import savestate_pkg::*;

    ss_region_t region_d;
    ss_offset_t offset_d;
    ss_offset_t offset_q;
    ss_word_t   wdata_q;
    logic       regs_write_q;
    logic       timer_write_q;
    logic       ram_write_q;

    // Address decode ahead of the request register
    always_comb begin
        region_d = REGION_NONE;
        offset_d = '0;
        if (ss_bus_addr == SS_ADDR_REGS0 || ss_bus_addr == SS_ADDR_REGS1) begin
            region_d = REGION_REGS;
            offset_d = ss_bus_addr - SS_ADDR_REGS0;
        end else if (ss_bus_addr == SS_ADDR_TIMER) begin
            region_d = REGION_TIMER;
            offset_d = ss_bus_addr - SS_ADDR_TIMER;
        end else if (ss_bus_addr >= SS_ADDR_RAM_BASE &&
                     int'(ss_bus_addr) < int'(SS_ADDR_RAM_BASE) + RAM_WORDS) begin
            region_d = REGION_RAM;
            offset_d = ss_bus_addr - SS_ADDR_RAM_BASE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            region        <= REGION_NONE;
            offset_q      <= '0;
            regs_write_q  <= 1'b0;
            timer_write_q <= 1'b0;
            ram_write_q   <= 1'b0;
        end else begin
            region        <= region_d;
            offset_q      <= offset_d;
            // Only the addressed target sees a strobe
            regs_write_q  <= ss_bus_wren && (region_d == REGION_REGS);
            timer_write_q <= ss_bus_wren && (region_d == REGION_TIMER);
            ram_write_q   <= ss_bus_wren && (region_d == REGION_RAM);
        end
    end

    always_ff @(posedge clk) begin
        wdata_q <= ss_bus_in;
    end

    assign regs_bus.offset  = offset_q;
    assign regs_bus.wdata   = wdata_q;
    assign regs_bus.write   = regs_write_q;

    assign timer_bus.offset = offset_q;
    assign timer_bus.wdata  = wdata_q;
    assign timer_bus.write  = timer_write_q;

    assign ram_bus.offset   = offset_q;
    assign ram_bus.wdata    = wdata_q;
    assign ram_bus.write    = ram_write_q;

endmodule

// ==== src/state_ram.sv ====
`timescale 1ns/1ps

module state_ram #(
    parameter int RAM_WORDS = 80
) (
    input  logic     clk,
    ss_bus_if.target bus
);
    import cpu_state_pkg::*;

    localparam int NIBBLES = RAM_WORDS * 8;

    // Eight consecutive cells per bus word
    nibble_t mem [NIBBLES];

    // Nibble 8k+j sits in bits 4j+3:4j of word k
    always_ff @(posedge clk) begin
        if (bus.write) begin
            for (int j = 0; j < 8; j++) begin
                mem[8 * int'(bus.offset) + j] <= bus.wdata[4 * j +: 4];
            end
        end
    end

    always_comb begin
        for (int j = 0; j < 8; j++) begin
            bus.rdata[4 * j +: 4] = mem[8 * int'(bus.offset) + j];
        end
    end

endmodule

// ==== test/savestate_checker.sv ====
`timescale 1ns/1ps

module savestate_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,
    input  savestate_pkg::ss_addr_t ss_bus_addr,
    input  logic                    ss_bus_wren,
    input  savestate_pkg::ss_word_t ss_bus_out
);
    import savestate_pkg::*;

    int       failures = 0;
    ss_addr_t prev_addr;
    logic     prev_wren;
    logic     same_read;

    always_ff @(posedge clk) begin
        prev_addr <= ss_bus_addr;
        prev_wren <= ss_bus_wren;
    end

    // Register word read twice in a row while the timer runs
    assign same_read = run && !ss_bus_wren && !prev_wren &&
                       ss_bus_addr <= SS_ADDR_REGS1 && ss_bus_addr == prev_addr;

    out_cleared_by_reset: assert property (@(posedge clk) reset |=> ss_bus_out == '0)
        else begin
            $error("ss_bus_out not zero after reset");
            failures++;
        end

    out_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(ss_bus_out))
        else begin
            $error("ss_bus_out has unknown bits");
            failures++;
        end

    // Both reads come out on consecutive cycles and must match
    regs_ignore_run: assert property (@(posedge clk) disable iff (reset)
        $past(same_read, 2) |-> ss_bus_out == $past(ss_bus_out))
        else begin
            $error("Register readback changed while run was high");
            failures++;
        end

endmodule

bind savestate_top savestate_checker check (.*);

// ==== test/savestate_monitor.sv ====
`timescale 1ns/1ps

module savestate_monitor (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    check_en,
    input  savestate_pkg::ss_word_t ss_bus_out
);
    import savestate_pkg::*;

    ss_word_t   exp_q[$];
    string      name_q[$];
    logic [1:0] valid_pipe;
    ss_word_t   expected;
    string      test;
    int         checks = 0;
    int         errors = 0;

    task automatic expect_word(input string name, input ss_word_t word);
        exp_q.push_back(word);
        name_q.push_back(name);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // A read captured at one edge is on ss_bus_out after the second edge
    always @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            if (valid_pipe[1]) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Readback arrived with no expected value queued");
                end else begin
                    expected = exp_q.pop_front();
                    test = name_q.pop_front();
                    checks++;
                    if (ss_bus_out !== expected) begin
                        errors++;
                        $display("[ERROR] %s: expected %08h, actual %08h",
                                 test, expected, ss_bus_out);
                    end
                end
            end
            valid_pipe <= {valid_pipe[0], check_en};
        end
    end

endmodule

// ==== test/savestate_tb.sv ====
`timescale 1ns/1ps

module savestate_tb;
    import savestate_pkg::*;
    import cpu_state_pkg::*;

    localparam int RAM_WORDS = 80;
    // Reset, then each test with its drain, then margin
    localparam int TIMEOUT_CYCLES = 16 + 12 + 24 + 340 + 180 + 16 + 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        run;
    ss_addr_t    ss_bus_addr;
    ss_word_t    ss_bus_in;
    logic        ss_bus_wren;
    ss_word_t    ss_bus_out;
    logic        check_en;
    int          cycle_count = 0;
    int          test_count = 0;
    int          start_errors;
    int          start_checks;
    string       test_name;

    // Reference machine state
    logic [29:0] m_core0;
    logic [31:0] m_core1;
    logic        m_tick;
    logic [6:0]  m_divider;
    logic [7:0]  m_counter;
    ss_word_t    m_ram [RAM_WORDS];

    always #20 clk = ~clk;

    savestate_top #(
        .RAM_WORDS(RAM_WORDS)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .ss_bus_addr(ss_bus_addr),
        .ss_bus_in  (ss_bus_in),
        .ss_bus_wren(ss_bus_wren),
        .ss_bus_out (ss_bus_out)
    );

    savestate_monitor monitor (
        .clk       (clk),
        .reset     (reset),
        .check_en  (check_en),
        .ss_bus_out(ss_bus_out)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with reads still pending", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // Word the bus has to return for addr
    function automatic ss_word_t expected_read(input ss_addr_t addr);
        int k;
        k = int'(addr) - 16;
        case (addr)
            8'h00: return {2'b00, m_core0};
            8'h01: return m_core1;
            8'h02: return {16'h0000, m_tick, m_divider, m_counter};
            default: begin
                if (k >= 0 && k < RAM_WORDS) begin
                    return m_ram[k];
                end
                return '0;
            end
        endcase
    endfunction

    task automatic load_defaults();
        // np, pc, a, b, then the four flags
        m_core0 = {NP_RESET, PC_RESET, 4'h0, 4'h0, 4'h0};
        m_core1 = '0;
        {m_tick, m_divider, m_counter} = '0;
    endtask

    task automatic record_write(input ss_addr_t addr, input ss_word_t data);
        int k;
        k = int'(addr) - 16;
        case (addr)
            8'h00: m_core0 = data[29:0];
            8'h01: m_core1 = data;
            8'h02: {m_tick, m_divider, m_counter} = data[15:0];
            default: begin
                if (k >= 0 && k < RAM_WORDS) begin
                    m_ram[k] = data;
                end
            end
        endcase
    endtask

    task automatic advance_timer(input int cycles);
        repeat (cycles) begin
            m_tick = (m_divider == 7'd127);
            if (m_tick) begin
                m_counter = m_counter + 8'd1;
            end
            m_divider = m_divider + 7'd1;
        end
    endtask

    task automatic drive(input ss_addr_t addr, input ss_word_t data, input logic wren,
                         input logic check);
        ss_bus_addr = addr;
        ss_bus_in   = data;
        ss_bus_wren = wren;
        check_en    = check;
        @(posedge clk);
        #2;
    endtask

    task automatic write_word(input ss_addr_t addr, input ss_word_t data);
        record_write(addr, data);
        drive(addr, data, 1'b1, 1'b0);
    endtask

    task automatic read_word(input ss_addr_t addr);
        monitor.expect_word(test_name, expected_read(addr));
        drive(addr, '0, 1'b0, 1'b1);
    endtask

    // One register address stays on the bus so the checker sees repeated reads
    task automatic run_timer(input ss_addr_t addr, input int cycles);
        run = 1'b1;
        repeat (cycles) begin
            drive(addr, '0, 1'b0, 1'b0);
        end
        run = 1'b0;
        advance_timer(cycles);
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        start_errors = monitor.errors;
        start_checks = monitor.checks;
    endtask

    task automatic end_test();
        while (monitor.pending() != 0) begin
            drive(8'h00, '0, 1'b0, 1'b0);
        end
        test_count++;
        $display("%s: %0d checks, %0d errors", test_name,
                 monitor.checks - start_checks, monitor.errors - start_errors);
    endtask

    initial begin
        void'($urandom(33567));
        reset       = 1'b1;
        run         = 1'b0;
        ss_bus_addr = '0;
        ss_bus_in   = '0;
        ss_bus_wren = 1'b0;
        check_en    = 1'b0;
        load_defaults();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        begin_test("reset defaults");
        read_word(8'h00);
        read_word(8'h01);
        read_word(8'h02);
        end_test();

        begin_test("register round trip");
        repeat (4) begin
            write_word(8'h00, $urandom);
            write_word(8'h01, $urandom);
            read_word(8'h00);
            read_word(8'h01);
        end
        end_test();

        begin_test("timer load and count");
        write_word(8'h02, $urandom);
        read_word(8'h02);
        // First run stops right on a divider wrap
        run_timer(8'h00, 128 - int'(m_divider));
        read_word(8'h02);
        run_timer(8'h01, 150 + int'($urandom_range(0, 40)));
        read_word(8'h02);
        end_test();

        begin_test("ram round trip");
        for (int k = 0; k < RAM_WORDS; k++) begin
            write_word(ss_addr_t'(16 + k), $urandom);
        end
        write_word(8'h15, $urandom);
        read_word(8'h15);
        for (int k = 0; k < RAM_WORDS; k++) begin
            read_word(ss_addr_t'(16 + k));
        end
        end_test();

        begin_test("unmapped addresses");
        write_word(8'h03, $urandom);
        write_word(8'h60, $urandom);
        read_word(8'h03);
        read_word(8'h60);
        read_word(8'h00);
        read_word(8'h02);
        read_word(8'h10);
        read_word(8'h5f);
        end_test();

        $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 test_count, monitor.checks, monitor.errors, uut.check.failures);
        if (monitor.errors == 0 && uut.check.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
